// ==== source/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    // widths with a meaning
    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [7:0]  hw_int_t;

    // 1:0 software, 9:2 hardware, 11 timer, 10 and 12 always zero
    typedef logic [12:0] int_vec_t;

    // write strobe from writeback
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        csr_data_t data;
    } csr_wr_t;

    // exception entry and return request
    typedef struct packed {
        logic      flush;
        logic      ertn;
        ecode_t    ecode;
        esubcode_t esubcode;
        csr_data_t era;
    } excp_req_t;

    // register bank contents handed to the read port
    typedef struct packed {
        csr_data_t crmd;
        csr_data_t prmd;
        csr_data_t ectl;
        csr_data_t estat;
        csr_data_t era;
        csr_data_t eentry;
        csr_data_t save0;
        csr_data_t save1;
        csr_data_t save2;
        csr_data_t save3;
        csr_data_t tid;
    } mode_state_t;

    // register numbers
    localparam csr_addr_t CSR_CRMD   = 14'h0;
    localparam csr_addr_t CSR_PRMD   = 14'h1;
    localparam csr_addr_t CSR_ECTL   = 14'h4;
    localparam csr_addr_t CSR_ESTAT  = 14'h5;
    localparam csr_addr_t CSR_ERA    = 14'h6;
    localparam csr_addr_t CSR_EENTRY = 14'hc;
    localparam csr_addr_t CSR_SAVE0  = 14'h30;
    localparam csr_addr_t CSR_SAVE1  = 14'h31;
    localparam csr_addr_t CSR_SAVE2  = 14'h32;
    localparam csr_addr_t CSR_SAVE3  = 14'h33;
    localparam csr_addr_t CSR_TID    = 14'h40;
    localparam csr_addr_t CSR_TCFG   = 14'h41;
    localparam csr_addr_t CSR_TVAL   = 14'h42;
    localparam csr_addr_t CSR_TICLR  = 14'h44;

    // crmd fields, prmd keeps its saved plv at the same position
    localparam int PLV_LSB = 0;
    localparam int IE_BIT  = 2;
    localparam int DA_BIT  = 3;
    localparam int PG_BIT  = 4;
    localparam int PIE_BIT = 2;

    // estat fields
    localparam int TI_BIT       = 11;
    localparam int ECODE_LSB    = 16;
    localparam int ESUBCODE_LSB = 22;

    // timer fields
    localparam int EN_BIT       = 0;
    localparam int PERIODIC_BIT = 1;
    localparam int CLR_BIT      = 0;

    localparam int EENTRY_ALIGN = 6;

endpackage

`default_nettype wire

// ==== source/csr_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module csr_timer #(
    parameter int TIMER_WIDTH = 32
) (
    input  logic                    clk,
    input  logic                    reset,
    input  csr_pkg::csr_wr_t        wr,
    output csr_pkg::csr_data_t      tcfg,
    output logic [TIMER_WIDTH-1:0]  tval,
    output logic                    timer_int
);

    logic               tcfg_wen;
    logic               ticlr_clr;
    logic               timer_en;
    logic               expire;
    csr_pkg::csr_data_t wr_init;
    csr_pkg::csr_data_t cfg_init;

    assign tcfg_wen  = wr.en && (wr.addr == csr_pkg::CSR_TCFG);
    assign ticlr_clr = wr.en && (wr.addr == csr_pkg::CSR_TICLR) && wr.data[csr_pkg::CLR_BIT];

    // initial value field counts in units of four cycles
    assign wr_init  = {wr.data[31:2], 2'b00};
    assign cfg_init = {tcfg[31:2], 2'b00};

    assign expire = timer_en && (tval == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg <= '0;
        end else if (tcfg_wen) begin
            tcfg <= wr.data;
        end
    end

    // one-shot mode drops the enable when the count runs out
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_en <= 1'b0;
        end else if (tcfg_wen) begin
            timer_en <= wr.data[csr_pkg::EN_BIT];
        end else if (expire) begin
            timer_en <= tcfg[csr_pkg::PERIODIC_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (tcfg_wen) begin
            tval <= wr_init[TIMER_WIDTH-1:0];
        end else if (timer_en) begin
            if (tval != '0) begin
                tval <= tval - 1'b1;
            end else if (tcfg[csr_pkg::PERIODIC_BIT]) begin
                tval <= cfg_init[TIMER_WIDTH-1:0];
            end else begin
                tval <= '1;
            end
        end
    end

    // clear wins over a same-cycle expiry
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (ticlr_clr) begin
            timer_int <= 1'b0;
        end else if (expire) begin
            timer_int <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/csr_mode_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module csr_mode_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  csr_pkg::csr_wr_t      wr,
    input  csr_pkg::excp_req_t    excp,
    input  csr_pkg::hw_int_t      interrupt,
    output csr_pkg::mode_state_t  state
);

    localparam int PLV_W   = $bits(csr_pkg::plv_t);
    localparam int ECODE_W = $bits(csr_pkg::ecode_t);
    localparam int ESUB_W  = $bits(csr_pkg::esubcode_t);
    localparam int HWI_W   = $bits(csr_pkg::hw_int_t);

    // ectl bit 10 is not implemented
    localparam csr_pkg::csr_data_t ECTL_MASK = 32'h0000_1bff;

    logic               wr_ok;
    csr_pkg::csr_data_t crmd;
    csr_pkg::csr_data_t prmd;
    csr_pkg::csr_data_t ectl;
    csr_pkg::csr_data_t estat;
    csr_pkg::csr_data_t era;
    csr_pkg::csr_data_t eentry;
    csr_pkg::csr_data_t save0;
    csr_pkg::csr_data_t save1;
    csr_pkg::csr_data_t save2;
    csr_pkg::csr_data_t save3;
    csr_pkg::csr_data_t tid;

    // a flushed instruction never writes
    assign wr_ok = wr.en && !excp.flush;

    // crmd: entry, then return, then write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd                   <= '0;
            crmd[csr_pkg::DA_BIT]  <= 1'b1;
        end else if (excp.flush) begin
            crmd[csr_pkg::PLV_LSB +: PLV_W] <= '0;
            crmd[csr_pkg::IE_BIT]           <= 1'b0;
        end else if (excp.ertn) begin
            crmd[csr_pkg::PLV_LSB +: PLV_W] <= prmd[csr_pkg::PLV_LSB +: PLV_W];
            crmd[csr_pkg::IE_BIT]           <= prmd[csr_pkg::PIE_BIT];
        end else if (wr.en && wr.addr == csr_pkg::CSR_CRMD) begin
            crmd[csr_pkg::PLV_LSB +: PLV_W] <= wr.data[csr_pkg::PLV_LSB +: PLV_W];
            crmd[csr_pkg::IE_BIT]           <= wr.data[csr_pkg::IE_BIT];
            crmd[csr_pkg::DA_BIT]           <= wr.data[csr_pkg::DA_BIT];
            crmd[csr_pkg::PG_BIT]           <= wr.data[csr_pkg::PG_BIT];
        end
    end

    // prmd saves the mode on entry
    always_ff @(posedge clk) begin
        if (reset) begin
            prmd <= '0;
        end else if (excp.flush) begin
            prmd[csr_pkg::PLV_LSB +: PLV_W] <= crmd[csr_pkg::PLV_LSB +: PLV_W];
            prmd[csr_pkg::PIE_BIT]          <= crmd[csr_pkg::IE_BIT];
        end else if (wr_ok && wr.addr == csr_pkg::CSR_PRMD) begin
            prmd[csr_pkg::PLV_LSB +: PLV_W] <= wr.data[csr_pkg::PLV_LSB +: PLV_W];
            prmd[csr_pkg::PIE_BIT]          <= wr.data[csr_pkg::PIE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ectl <= '0;
        end else if (wr_ok && wr.addr == csr_pkg::CSR_ECTL) begin
            ectl <= wr.data & ECTL_MASK;
        end
    end

    // timer bit 11 lives in the timer block
    always_ff @(posedge clk) begin
        if (reset) begin
            estat <= '0;
        end else begin
            estat[2 +: HWI_W] <= interrupt;
            if (excp.flush) begin
                estat[csr_pkg::ECODE_LSB +: ECODE_W]   <= excp.ecode;
                estat[csr_pkg::ESUBCODE_LSB +: ESUB_W] <= excp.esubcode;
            end else if (wr_ok && wr.addr == csr_pkg::CSR_ESTAT) begin
                estat[1:0] <= wr.data[1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (excp.flush) begin
            era <= excp.era;
        end else if (wr_ok && wr.addr == csr_pkg::CSR_ERA) begin
            era <= wr.data;
        end
    end

    // entry vector keeps its low bits at zero
    always_ff @(posedge clk) begin
        if (reset) begin
            eentry <= '0;
        end else if (wr_ok && wr.addr == csr_pkg::CSR_EENTRY) begin
            eentry[31:csr_pkg::EENTRY_ALIGN] <= wr.data[31:csr_pkg::EENTRY_ALIGN];
        end
    end

    // scratch registers for the handler
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            case (wr.addr)
                csr_pkg::CSR_SAVE0: save0 <= wr.data;
                csr_pkg::CSR_SAVE1: save1 <= wr.data;
                csr_pkg::CSR_SAVE2: save2 <= wr.data;
                csr_pkg::CSR_SAVE3: save3 <= wr.data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tid <= '0;
        end else if (wr_ok && wr.addr == csr_pkg::CSR_TID) begin
            tid <= wr.data;
        end
    end

    assign state = '{
        crmd:   crmd,
        prmd:   prmd,
        ectl:   ectl,
        estat:  estat,
        era:    era,
        eentry: eentry,
        save0:  save0,
        save1:  save1,
        save2:  save2,
        save3:  save3,
        tid:    tid
    };

endmodule

`default_nettype wire

// ==== source/csr_read_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module csr_read_port #(
    parameter int TIMER_WIDTH = 32
) (
    input  csr_pkg::mode_state_t    state,
    input  csr_pkg::csr_data_t      tcfg,
    input  logic [TIMER_WIDTH-1:0]  tval,
    input  logic                    timer_int,
    input  csr_pkg::csr_addr_t      rd_addr,
    output csr_pkg::csr_data_t      rd_data,
    output logic                    has_int
);

    localparam int IV_W = $bits(csr_pkg::int_vec_t);

    csr_pkg::csr_data_t estat_vis;
    csr_pkg::int_vec_t  int_pending;

    // timer flag is held outside the register bank
    always_comb begin
        estat_vis                  = state.estat;
        estat_vis[csr_pkg::TI_BIT] = timer_int;
    end

    assign int_pending = state.ectl[IV_W-1:0] & estat_vis[IV_W-1:0];
    assign has_int     = (|int_pending) && state.crmd[csr_pkg::IE_BIT];

    // ticlr and unknown numbers read zero
    always_comb begin
        rd_data = '0;
        case (rd_addr)
            csr_pkg::CSR_CRMD:   rd_data = state.crmd;
            csr_pkg::CSR_PRMD:   rd_data = state.prmd;
            csr_pkg::CSR_ECTL:   rd_data = state.ectl;
            csr_pkg::CSR_ESTAT:  rd_data = estat_vis;
            csr_pkg::CSR_ERA:    rd_data = state.era;
            csr_pkg::CSR_EENTRY: rd_data = state.eentry;
            csr_pkg::CSR_SAVE0:  rd_data = state.save0;
            csr_pkg::CSR_SAVE1:  rd_data = state.save1;
            csr_pkg::CSR_SAVE2:  rd_data = state.save2;
            csr_pkg::CSR_SAVE3:  rd_data = state.save3;
            csr_pkg::CSR_TID:    rd_data = state.tid;
            csr_pkg::CSR_TCFG:   rd_data = tcfg;
            // zero-extended when the counter is narrow
            csr_pkg::CSR_TVAL:   rd_data[TIMER_WIDTH-1:0] = tval;
            default:             rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/csr_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module csr_unit #(
    parameter int TIMER_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  csr_pkg::csr_wr_t      wr,
    input  csr_pkg::excp_req_t    excp,
    input  csr_pkg::hw_int_t      interrupt,
    input  csr_pkg::csr_addr_t    rd_addr,
    output csr_pkg::csr_data_t    rd_data,
    output logic                  has_int,
    output csr_pkg::csr_data_t    eentry_out,
    output csr_pkg::csr_data_t    era_out,
    output csr_pkg::plv_t         plv_out,
    output csr_pkg::csr_data_t    tid_out
);

    localparam int PLV_W = $bits(csr_pkg::plv_t);

    csr_pkg::mode_state_t    state;
    csr_pkg::csr_data_t      tcfg;
    logic [TIMER_WIDTH-1:0]  tval;
    logic                    timer_int;

    csr_timer #(
        .TIMER_WIDTH (TIMER_WIDTH)
    ) u_timer (
        .clk       (clk),
        .reset     (reset),
        .wr        (wr),
        .tcfg      (tcfg),
        .tval      (tval),
        .timer_int (timer_int)
    );

    csr_mode_regs u_mode_regs (
        .clk       (clk),
        .reset     (reset),
        .wr        (wr),
        .excp      (excp),
        .interrupt (interrupt),
        .state     (state)
    );

    csr_read_port #(
        .TIMER_WIDTH (TIMER_WIDTH)
    ) u_read_port (
        .state     (state),
        .tcfg      (tcfg),
        .tval      (tval),
        .timer_int (timer_int),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .has_int   (has_int)
    );

    // fetch and mode outputs straight from the registers
    assign eentry_out = state.eentry;
    assign era_out    = state.era;
    assign plv_out    = state.crmd[csr_pkg::PLV_LSB +: PLV_W];
    assign tid_out    = state.tid;

endmodule

`default_nettype wire

// ==== verif/csr_unit_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module csr_unit_asserts (
    input logic               clk,
    input logic               reset,
    input csr_pkg::excp_req_t excp,
    input logic               ie,
    input logic               has_int,
    input csr_pkg::csr_data_t eentry_out
);

    excp_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(excp.flush && excp.ertn)
    ) else $error("flush and ertn are high in the same cycle");

    // no request while interrupts are masked globally
    no_int_without_ie: assert property (
        @(posedge clk) disable iff (reset) !ie |-> !has_int
    ) else $error("has_int is high while CRMD IE is clear");

    eentry_aligned: assert property (
        @(posedge clk) disable iff (reset) eentry_out[5:0] == '0
    ) else $error("low bits of eentry_out are not zero");

endmodule

bind csr_unit csr_unit_asserts u_asserts (
    .clk        (clk),
    .reset      (reset),
    .excp       (excp),
    .ie         (state.crmd[csr_pkg::IE_BIT]),
    .has_int    (has_int),
    .eentry_out (eentry_out)
);

`default_nettype wire

// ==== verif/csr_unit_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module csr_unit_tb;

    localparam int PERIOD = 4;

    logic               clk;
    logic               reset;
    csr_pkg::csr_wr_t   wr;
    csr_pkg::excp_req_t excp;
    csr_pkg::hw_int_t   interrupt;
    csr_pkg::csr_addr_t rd_addr;
    csr_pkg::csr_data_t rd_data;
    logic               has_int;
    csr_pkg::csr_data_t eentry_out;
    csr_pkg::csr_data_t era_out;
    csr_pkg::plv_t      plv_out;
    csr_pkg::csr_data_t tid_out;

    // reference model, indexed by register number
    logic [31:0] m_reg [0:127];
    logic [31:0] m_tval;
    logic        m_ten;
    logic        m_ti;
    logic [7:0]  m_hw;
    logic [15:0] lfsr_state;
    int          n_lines;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;
    string       test_name;

    csr_unit #(.TIMER_WIDTH(32)) u_dut (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr),
        .excp       (excp),
        .interrupt  (interrupt),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .has_int    (has_int),
        .eentry_out (eentry_out),
        .era_out    (era_out),
        .plv_out    (plv_out),
        .tid_out    (tid_out)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] write_mask(logic [13:0] a);
        case (a)
            csr_pkg::CSR_CRMD:   return 32'h0000_001f;
            csr_pkg::CSR_PRMD:   return 32'h0000_0007;
            csr_pkg::CSR_ECTL:   return 32'h0000_1bff;
            csr_pkg::CSR_ESTAT:  return 32'h0000_0003;
            csr_pkg::CSR_EENTRY: return 32'hffff_ffc0;
            csr_pkg::CSR_ERA, csr_pkg::CSR_SAVE0, csr_pkg::CSR_SAVE1, csr_pkg::CSR_SAVE2,
            csr_pkg::CSR_SAVE3, csr_pkg::CSR_TID, csr_pkg::CSR_TCFG: return 32'hffff_ffff;
            default:             return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] model_read(logic [13:0] a);
        if (a == csr_pkg::CSR_ESTAT) begin
            return m_reg[a] | ({31'b0, m_ti} << 11) | ({24'b0, m_hw} << 2);
        end
        if (a == csr_pkg::CSR_TVAL) begin
            return m_tval;
        end
        if (write_mask(a) == 0) begin
            return 32'h0;
        end
        return m_reg[a];
    endfunction

    function automatic logic model_has_int();
        logic [31:0] st;
        st = model_read(csr_pkg::CSR_ESTAT);
        return (|(m_reg[csr_pkg::CSR_ECTL][12:0] & st[12:0])) && m_reg[csr_pkg::CSR_CRMD][2];
    endfunction

    // one rising edge of the registers, from the inputs driven now
    task automatic model_edge();
        logic        expire;
        logic [31:0] cfg;
        logic [13:0] a;
        expire = m_ten && (m_tval == 0);
        cfg = m_reg[csr_pkg::CSR_TCFG];
        a = wr.addr;
        if (wr.en && a == csr_pkg::CSR_TCFG) begin
            m_ten = wr.data[0];
            m_tval = wr.data & ~32'h3;
        end else if (m_ten) begin
            m_ten = expire ? cfg[1] : 1'b1;
            m_tval = (m_tval != 0) ? m_tval - 1 : (cfg[1] ? cfg & ~32'h3 : '1);
        end
        if (wr.en && a == csr_pkg::CSR_TICLR && wr.data[0]) begin
            m_ti = 1'b0;
        end else if (expire) begin
            m_ti = 1'b1;
        end
        m_hw = interrupt;
        if (excp.flush) begin
            m_reg[csr_pkg::CSR_PRMD] = m_reg[csr_pkg::CSR_CRMD] & 32'h7;
            m_reg[csr_pkg::CSR_CRMD] = m_reg[csr_pkg::CSR_CRMD] & ~32'h7;
            m_reg[csr_pkg::CSR_ESTAT] = (m_reg[csr_pkg::CSR_ESTAT] & 32'h3)
                | ({23'b0, excp.esubcode} << 22) | ({26'b0, excp.ecode} << 16);
            m_reg[csr_pkg::CSR_ERA] = excp.era;
        end else begin
            if (excp.ertn) begin
                m_reg[0] = (m_reg[0] & ~32'h7) | (m_reg[csr_pkg::CSR_PRMD] & 32'h7);
            end
            if (wr.en && a < 128 && !(excp.ertn && a == csr_pkg::CSR_CRMD)) begin
                m_reg[a] = (m_reg[a] & ~write_mask(a)) | (wr.data & write_mask(a));
            end
        end
    endtask

    task automatic tick();
        @(posedge clk);
        model_edge();
        @(negedge clk);
        wr.en = 1'b0;
        excp.flush = 1'b0;
        excp.ertn = 1'b0;
    endtask

    task automatic next_rand(output logic [31:0] v);
        for (int i = 0; i < 32; i++) begin
            lfsr_state = {lfsr_state[14:0],
                lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            v[i] = lfsr_state[0];
        end
    endtask

    task automatic check_read(logic [13:0] a, string exp_s, logic exp_int);
        logic [31:0] exp_v;
        logic [31:0] mod_v;
        logic        mod_int;
        rd_addr = a;
        #1;
        mod_v = model_read(a);
        mod_int = model_has_int();
        if (exp_s != "-") begin
            void'($sscanf(exp_s, "%h", exp_v));
            assert (exp_v == mod_v) else begin
                $display("pattern value %h for register %h disagrees with the model",
                    exp_v, a);
                test_errors++;
            end
        end
        assert (exp_int == mod_int) else begin
            $display("pattern has_int for register %h disagrees with the model", a);
            test_errors++;
        end
        assert (rd_data === mod_v) else begin
            $display("mismatch at %0t rd_data[%h] expected %h actual %h",
                $time, a, mod_v, rd_data);
            test_errors++;
        end
        assert (has_int === mod_int) else begin
            $display("mismatch at %0t has_int expected %b actual %b",
                $time, mod_int, has_int);
            test_errors++;
        end
        if (a == csr_pkg::CSR_CRMD) begin
            assert (plv_out === mod_v[1:0]) else begin
                $display("mismatch at %0t plv_out expected %h actual %h",
                    $time, mod_v[1:0], plv_out);
                test_errors++;
            end
        end
        if (a == csr_pkg::CSR_ERA) begin
            assert (era_out === mod_v) else begin
                $display("mismatch at %0t era_out expected %h actual %h",
                    $time, mod_v, era_out);
                test_errors++;
            end
        end
        if (a == csr_pkg::CSR_EENTRY) begin
            assert (eentry_out === mod_v) else begin
                $display("mismatch at %0t eentry_out expected %h actual %h",
                    $time, mod_v, eentry_out);
                test_errors++;
            end
        end
        if (a == csr_pkg::CSR_TID) begin
            assert (tid_out === mod_v) else begin
                $display("mismatch at %0t tid_out expected %h actual %h",
                    $time, mod_v, tid_out);
                test_errors++;
            end
        end
        tick();
    endtask

    task automatic finish_test();
        if (test_name != "") begin
            tests_run++;
            total_errors += test_errors;
            if (test_errors != 0) begin
                tests_failed++;
            end
            $display("test %s: %0d errors", test_name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        wait (n_lines > 0);
        #(n_lines * 4 * PERIOD + 200);
        $display("timeout: the pattern run did not finish in its time budget");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int          fd;
        string       line;
        string       op;
        string       exp_s;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] v [0:5];
        wr = '0;
        excp = '0;
        interrupt = '0;
        rd_addr = '0;
        reset = 1'b1;
        lfsr_state = 16'd92;
        test_name = "";
        for (int i = 0; i < 128; i++) begin
            m_reg[i] = 32'h0;
        end
        m_reg[csr_pkg::CSR_CRMD] = 32'h8;
        {m_tval, m_ten, m_ti, m_hw} = '0;
        fd = $fopen("verif/csr_unit_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file");
            $display("Simulation failed");
            $finish;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n_lines++;
            end
            $fclose(fd);
            fd = $fopen("verif/csr_unit_patterns.txt", "r");
            repeat (4) @(negedge clk);
            reset = 1'b0;
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%s", op) < 1 || op.substr(0, 0) == "#") begin
                    continue;
                end
                case (op)
                    "test": begin
                        finish_test();
                        void'($sscanf(line, "%s %s", op, test_name));
                    end
                    "write", "wrand": begin
                        void'($sscanf(line, "%s %h %h", op, a, d));
                        if (op == "wrand") begin
                            next_rand(d);
                        end
                        wr = '{en: 1'b1, addr: a[13:0], data: d};
                        tick();
                    end
                    "excp": begin
                        void'($sscanf(line, "%s %h %h %h %h %h %h", op,
                            v[0], v[1], v[2], v[3], v[4], v[5]));
                        excp = '{flush: 1'b1, ertn: 1'b0, ecode: v[0][5:0],
                            esubcode: v[1][8:0], era: v[2]};
                        wr = '{en: v[3][0], addr: v[4][13:0], data: v[5]};
                        tick();
                    end
                    "ertn": begin
                        excp.ertn = 1'b1;
                        tick();
                    end
                    "idle": begin
                        void'($sscanf(line, "%s %h", op, d));
                        repeat (d) tick();
                    end
                    "int": begin
                        void'($sscanf(line, "%s %h", op, d));
                        interrupt = d[7:0];
                        tick();
                    end
                    "read": begin
                        void'($sscanf(line, "%s %h %s %h", op, a, exp_s, d));
                        check_read(a[13:0], exp_s, d[0]);
                    end
                    default: begin
                        $display("unknown opcode %s in the pattern file", op);
                        test_errors++;
                    end
                endcase
            end
            $fclose(fd);
            finish_test();
            $display("tests %0d, failed tests %0d, failed checks %0d",
                tests_run, tests_failed, total_errors);
            if (total_errors == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== csr_unit.f ====
source/csr_pkg.sv
source/csr_timer.sv
source/csr_mode_regs.sv
source/csr_read_port.sv
source/csr_unit.sv
verif/csr_unit_asserts.sv
verif/csr_unit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - source/csr_pkg.sv
  - source/csr_timer.sv
  - source/csr_mode_regs.sv
  - source/csr_read_port.sv
  - source/csr_unit.sv
  - target: test
    files:
      - verif/csr_unit_asserts.sv
      - verif/csr_unit_tb.sv

// ==== verif/csr_unit_patterns.txt ====
# op and hex operands; read: addr, expected data (- takes the model), expected has_int
# write addr data | wrand addr | excp ecode esub era wen waddr wdata | ertn | idle n | int lines
test reset_values
read 0 8 0
read 1 0 0
read 4 0 0
read 5 0 0
read c 0 0
read 40 0 0
read 41 0 0
test register_access
wrand 30
wrand 33
wrand 40
wrand c
wrand 6
read 30 - 0
read 33 - 0
read 40 - 0
read c - 0
read 6 - 0
test exception_entry
write 0 f
excp d 1 1c000040 1 30 0
read 1 7 0
read 0 8 0
read 5 4d0000 0
read 6 1c000040 0
read 30 - 0
test exception_return
ertn
read 0 f 0
test interrupt_request
write 4 3
write 5 1
read 5 4d0001 1
write 5 0
read 5 4d0000 0
write 4 10
int 4
read 5 4d0010 1
int 0
read 5 4d0000 0
test timer
write 4 800
write 41 9
read 42 8 0
idle 8
read 5 4d0800 1
read 42 ffffffff 1
write 44 1
read 5 4d0000 0
write 41 b
idle 9
read 5 4d0800 1
read 42 7 1
